// File: compile.f
source/timetag_pkg.sv
source/cmd_parser.sv
source/control_regs.sv
source/pulse_sequencer.sv
source/detector_tagger.sv
source/record_fifo.sv
source/record_serializer.sv
source/timetag_top.sv
bench/timetag_properties.sv
bench/timetag_bench.sv

// File: bench/timetag_bench.sv
`timescale 1ns/1ps
`default_nettype none

module timetag_bench import timetag_pkg::*; ();

	localparam logic [31:0] SEED = 32'h8a64;
	localparam int RESET_CYCLES = 10;

	logic clk = 1'b0;
	logic reset;
	logic [7:0] cmd_data;
	logic cmd_valid;
	logic cmd_ready;
	logic [NUM_DETECTORS-1:0] detectors;
	logic [NUM_LASERS-1:0] laser_en;
	logic [7:0] out_data;
	logic out_valid;
	logic out_ready;

	int cycle = 0;
	int tag_zero = 0;
	int last_accept = 0;
	int byte_count = 0;
	logic [NUM_DETECTORS-1:0] active_mask = '0;
	// 0 holds out_ready low, 1 holds it high, 2 randomizes it
	logic [1:0] ready_mode = 2'd1;
	logic [31:0] gap_state = SEED;
	logic [31:0] ready_state;
	logic [31:0] assembling;
	event_record_t expected_q [$];
	event_record_t collected_q [$];

	timetag_top uut (
		.clk(clk), .reset(reset),
		.cmd_data(cmd_data), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.detectors(detectors), .laser_en(laser_en),
		.out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int unsigned draw_random();
		gap_state = xorshift(gap_state);
		return gap_state;
	endfunction

	// Tags count cycles from the edge where the last TAG_CTRL write was accepted
	function automatic event_record_t predict_record(input bit is_marker,
			input logic [3:0] value, input int drive_cycle);
		event_record_t r;
		r = '0;
		if (is_marker) begin
			r.marker.kind = MARKER_KIND;
			r.marker.running = (value != 4'h0);
			r.marker.mask = value;
		end else begin
			r.tag.channel = value;
			r.tag.timestamp = TIME_WIDTH'(drive_cycle - tag_zero);
		end
		return r;
	endfunction

	task automatic fail_with(input string line);
		$display("%s", line);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_tag(input event_record_t got, input event_record_t exp);
		if (got.tag.channel !== exp.tag.channel)
			fail_with($sformatf("** Error: tag channel got %h expected %h",
				got.tag.channel, exp.tag.channel));
		if (got.tag.timestamp !== exp.tag.timestamp)
			fail_with($sformatf("** Error: tag timestamp got %h expected %h",
				got.tag.timestamp, exp.tag.timestamp));
	endtask

	task automatic check_marker(input event_record_t got, input event_record_t exp);
		if (got !== exp)
			fail_with($sformatf("** Error: marker record got %h expected %h", got, exp));
	endtask

	task automatic check_laser(input logic [NUM_LASERS-1:0] got,
			input logic [NUM_LASERS-1:0] exp);
		if (got !== exp)
			fail_with($sformatf("** Error: laser_en got %h expected %h at cycle %0d",
				got, exp, cycle));
	endtask

	task automatic check_ready(input logic got, input logic exp);
		if (got !== exp)
			fail_with($sformatf("** Error: cmd_ready got %h expected %h at cycle %0d",
				got, exp, cycle));
	endtask

	// The parser never stalls once it has left reset
	always @(negedge clk) begin
		if (reset)
			check_ready(cmd_ready, 1'b0);
		else if (cycle > RESET_CYCLES)
			check_ready(cmd_ready, 1'b1);
	end

	// Bytes are settled by the falling edge, ahead of the edge that transfers them
	always @(negedge clk) begin
		if (!reset && out_valid && out_ready) begin
			assembling[byte_count*8 +: 8] = out_data;
			if (byte_count == 3) begin
				collected_q.push_back(assembling);
				byte_count = 0;
			end else begin
				byte_count = byte_count + 1;
			end
		end
	end

	always @(posedge clk) begin : compare_records
		event_record_t got;
		event_record_t exp;
		if (uut.props.failures != 0)
			fail_with("a bound assertion on the DUT failed");
		while (collected_q.size() > 0) begin
			got = collected_q.pop_front();
			if (expected_q.size() == 0) begin
				fail_with($sformatf("record %h arrived while none was expected", got));
			end else begin
				exp = expected_q.pop_front();
				if (exp.marker.kind == MARKER_KIND)
					check_marker(got, exp);
				else
					check_tag(got, exp);
			end
		end
	end

	initial begin
		logic [1:0] mode;
		out_ready = 1'b0;
		ready_state = SEED ^ 32'h5555_0000;
		forever begin
			@(posedge clk);
			mode = ready_mode;
			#5;
			ready_state = xorshift(ready_state);
			case (mode)
				2'd0: out_ready = 1'b0;
				2'd1: out_ready = 1'b1;
				default: out_ready = ready_state[7];
			endcase
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic send_byte(input logic [7:0] value);
		int guard;
		guard = 0;
		cmd_data = value;
		cmd_valid = 1'b1;
		while (cmd_ready !== 1'b1) begin
			next_cycle();
			guard++;
			if (guard > 100)
				fail_with("timed out waiting for cmd_ready");
		end
		// Ready is high now, so the byte goes in at the next edge
		last_accept = cycle + 1;
		next_cycle();
		cmd_valid = 1'b0;
		idle_cycles(draw_random() % 4);
	endtask

	task automatic send_command(input logic [7:0] addr, input logic [31:0] value,
			input int len);
		send_byte(CMD_HEADER);
		send_byte(8'(len));
		send_byte(addr);
		for (int i = 0; i < len; i++)
			send_byte(value[i*8 +: 8]);
	endtask

	task automatic set_tagging(input logic [3:0] mask);
		send_command(REG_TAG_CTRL, 32'(mask), 1);
		tag_zero = last_accept;
		active_mask = mask;
		expected_q.push_back(predict_record(1'b1, mask, 0));
		idle_cycles(4);
	endtask

	task automatic pulse_detector(input int ch, input int width, input int tail);
		detectors[ch] = 1'b1;
		if (active_mask[ch])
			expected_q.push_back(predict_record(1'b0, 4'(ch), cycle));
		idle_cycles(width);
		detectors[ch] = 1'b0;
		idle_cycles(tail);
	endtask

	task automatic wait_outstanding(input int limit);
		int guard;
		guard = 0;
		while (expected_q.size() > limit) begin
			next_cycle();
			guard++;
			if (guard > 5000)
				fail_with($sformatf("timed out with %0d records still expected",
					expected_q.size()));
		end
	endtask

	task automatic check_sequence(input logic [3:0] mask, input int high, input int low);
		int start;
		int stop;
		send_command(REG_SEQ_HIGH, high, 2);
		send_command(REG_SEQ_LOW, low, 2);
		send_command(REG_SEQ_MASK, 32'(mask), 1);
		send_command(REG_SEQ_CTRL, 1, 1);
		// Enables rise two edges after the start write goes in
		start = last_accept + 2;
		while (cycle < start + 4 * (high + low)) begin
			if (cycle < start)
				check_laser(laser_en, '0);
			else
				check_laser(laser_en, ((cycle - start) % (high + low) < high) ? mask : '0);
			next_cycle();
		end
		send_command(REG_SEQ_CTRL, 0, 1);
		stop = last_accept + 2;
		while (cycle < stop + 8) begin
			if (cycle >= stop)
				check_laser(laser_en, '0);
			next_cycle();
		end
	endtask

	initial begin
		int ch;
		reset = 1'b1;
		cmd_data = 8'h00;
		cmd_valid = 1'b0;
		detectors = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		reset = 1'b0;
		check_laser(laser_en, '0);

		// Junk, a zero length and an oversize length must all be dropped
		for (int i = 0; i < 6; i++)
			send_byte(8'hFF);
		send_byte(8'h12);
		send_byte(CMD_HEADER);
		send_byte(8'h00);
		send_byte(8'hFF);
		send_byte(8'hFF);
		send_byte(CMD_HEADER);
		send_byte(8'h09);
		send_byte(REG_TAG_CTRL);
		send_byte(8'h03);
		set_tagging(4'h3);
		wait_outstanding(0);
		idle_cycles(20);

		pulse_detector(0, 4, 10);
		pulse_detector(1, 5, 12);
		pulse_detector(2, 4, 10);
		pulse_detector(1, 4, 9);
		pulse_detector(0, 6, 11);
		wait_outstanding(0);
		idle_cycles(20);

		check_sequence(4'h5, 3, 5);

		ready_mode = 2'd0;
		idle_cycles(4);
		for (int i = 0; i < 12; i++)
			pulse_detector(i % 2, 4, 4);
		set_tagging(4'h0);
		ready_mode = 2'd1;
		wait_outstanding(0);
		idle_cycles(20);

		ready_mode = 2'd2;
		for (int batch = 0; batch < 8; batch++) begin
			set_tagging(4'(draw_random() % 15 + 1));
			for (int i = 0; i < 50; i++) begin
				wait_outstanding(7);
				ch = draw_random() % 4;
				pulse_detector(ch, 4 + draw_random() % 4, 4 + draw_random() % 4);
			end
		end
		set_tagging(4'h0);
		wait_outstanding(0);
		idle_cycles(40);

		if (expected_q.size() != 0 || collected_q.size() != 0 || uut.props.failures != 0) begin
			fail_with("records or assertion failures were left at the end of the run");
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: bench/timetag_properties.sv
`timescale 1ns/1ps
`default_nettype none

module timetag_properties import timetag_pkg::*; (
	input wire clk,
	input wire reset,
	input wire [7:0] out_data,
	input wire out_valid,
	input wire out_ready,
	input wire seq_run,
	input wire [NUM_LASERS-1:0] seq_mask,
	input wire [NUM_LASERS-1:0] laser_en
);

	int failures = 0;

	// A stalled output byte holds until the host takes it
	stall_holds: assert property (@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
	else begin
		$error("out_data changed while the output was stalled");
		failures++;
	end

	stop_clears: assert property (@(posedge clk) disable iff (reset)
		$fell(seq_run) |=> (laser_en == '0))
	else begin
		$error("laser_en still set one cycle after the sequencer stopped");
		failures++;
	end

	mask_respected: assert property (@(posedge clk) disable iff (reset)
		(laser_en & ~seq_mask) == '0)
	else begin
		$error("laser_en drives a laser outside seq_mask");
		failures++;
	end

endmodule

bind timetag_top timetag_properties props (
	.clk(clk),
	.reset(reset),
	.out_data(out_data),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.seq_run(seq_run),
	.seq_mask(seq_mask),
	.laser_en(laser_en)
);

`default_nettype wire

// File: source/timetag_top.sv
`timescale 1ns/1ps
`default_nettype none

module timetag_top import timetag_pkg::*; (
	input wire clk,
	input wire reset,
	input wire [7:0] cmd_data,
	input wire cmd_valid,
	output logic cmd_ready,
	input wire [NUM_DETECTORS-1:0] detectors,
	output logic [NUM_LASERS-1:0] laser_en,
	output logic [7:0] out_data,
	output logic out_valid,
	input wire out_ready
);

	logic reg_wr;
	logic [7:0] reg_addr;
	logic [31:0] reg_data;
	logic [NUM_DETECTORS-1:0] tag_mask;
	logic tag_run;
	logic tag_event;
	logic seq_run;
	logic [COUNT_WIDTH-1:0] seq_high;
	logic [COUNT_WIDTH-1:0] seq_low;
	logic [NUM_LASERS-1:0] seq_mask;
	logic [31:0] rec_data;
	logic rec_valid;
	logic rec_ready;
	logic [31:0] fifo_data;
	logic fifo_valid;
	logic fifo_ready;

	cmd_parser parser (
		.clk(clk), .reset(reset),
		.cmd_data(cmd_data), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.reg_wr(reg_wr), .reg_addr(reg_addr), .reg_data(reg_data)
	);

	control_regs regs (
		.clk(clk), .reset(reset),
		.reg_wr(reg_wr), .reg_addr(reg_addr), .reg_data(reg_data),
		.tag_mask(tag_mask), .tag_run(tag_run), .tag_event(tag_event),
		.seq_run(seq_run), .seq_high(seq_high), .seq_low(seq_low), .seq_mask(seq_mask)
	);

	pulse_sequencer sequencer (
		.clk(clk), .reset(reset),
		.seq_run(seq_run), .seq_high(seq_high), .seq_low(seq_low), .seq_mask(seq_mask),
		.laser_en(laser_en)
	);

	detector_tagger tagger (
		.clk(clk), .reset(reset),
		.detectors(detectors), .tag_mask(tag_mask), .tag_run(tag_run),
		.tag_event(tag_event),
		.rec_data(rec_data), .rec_valid(rec_valid), .rec_ready(rec_ready)
	);

	record_fifo fifo (
		.clk(clk), .reset(reset),
		.rec_data(rec_data), .rec_valid(rec_valid), .rec_ready(rec_ready),
		.fifo_data(fifo_data), .fifo_valid(fifo_valid), .fifo_ready(fifo_ready)
	);

	record_serializer serializer (
		.clk(clk), .reset(reset),
		.fifo_data(fifo_data), .fifo_valid(fifo_valid), .fifo_ready(fifo_ready),
		.out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
	);

endmodule

`default_nettype wire

// File: source/record_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module record_serializer (
	input wire clk,
	input wire reset,
	input wire [31:0] fifo_data,
	input wire fifo_valid,
	output logic fifo_ready,
	output logic [7:0] out_data,
	output logic out_valid,
	input wire out_ready
);

	logic [31:0] word;
	logic [1:0] byte_idx;
	logic full;

	assign fifo_ready = !full;
	assign out_valid = full;
	assign out_data = word[byte_idx*8 +: 8];

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
			byte_idx <= 2'd0;
		end else if (fifo_valid && fifo_ready) begin
			full <= 1'b1;
			byte_idx <= 2'd0;
		end else if (out_valid && out_ready) begin
			// Last byte gone frees the holding register
			if (byte_idx == 2'd3)
				full <= 1'b0;
			byte_idx <= byte_idx + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_valid && fifo_ready)
			word <= fifo_data;
	end

endmodule

`default_nettype wire

// File: source/record_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module record_fifo import timetag_pkg::*; (
	input wire clk,
	input wire reset,
	input wire [31:0] rec_data,
	input wire rec_valid,
	output logic rec_ready,
	output logic [31:0] fifo_data,
	output logic fifo_valid,
	input wire fifo_ready
);

	logic [31:0] mem [FIFO_DEPTH];
	logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
	logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
	logic [FIFO_ADDR_WIDTH:0] count;
	logic do_write;
	logic do_read;

	assign rec_ready = count != FIFO_DEPTH;
	assign fifo_valid = count != '0;
	assign fifo_data = mem[rd_ptr];
	assign do_write = rec_valid && rec_ready;
	assign do_read = fifo_valid && fifo_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= rec_data;
	end

endmodule

`default_nettype wire

// File: source/detector_tagger.sv
`timescale 1ns/1ps
`default_nettype none

module detector_tagger import timetag_pkg::*; (
	input wire clk,
	input wire reset,
	input wire [NUM_DETECTORS-1:0] detectors,
	input wire [NUM_DETECTORS-1:0] tag_mask,
	input wire tag_run,
	input wire tag_event,
	output logic [31:0] rec_data,
	output logic rec_valid,
	input wire rec_ready
);

	logic [NUM_DETECTORS-1:0] sync_a;
	logic [NUM_DETECTORS-1:0] sync_b;
	logic [NUM_DETECTORS-1:0] sync_prev;
	logic [NUM_DETECTORS-1:0] edges;
	logic [NUM_DETECTORS-1:0] accept;
	logic [NUM_DETECTORS-1:0] take;
	logic [NUM_DETECTORS-1:0] pending;
	logic [TIME_WIDTH-1:0] pending_time [NUM_DETECTORS];
	logic [TIME_WIDTH-1:0] timestamp;
	logic marker_pending;
	logic marker_run;
	logic [NUM_DETECTORS-1:0] marker_mask;
	logic offer;
	logic pick_found;
	logic [$clog2(NUM_DETECTORS)-1:0] pick;
	event_record_t rec_q;

	assign edges = sync_b & ~sync_prev & tag_mask;
	assign offer = !rec_valid || rec_ready;

	// Lowest pending channel wins
	always_comb begin
		pick = '0;
		pick_found = 1'b0;
		for (int i = NUM_DETECTORS - 1; i >= 0; i--) begin
			if (pending[i]) begin
				pick = i[$clog2(NUM_DETECTORS)-1:0];
				pick_found = 1'b1;
			end
		end
	end

	assign take = (offer && !marker_pending && pick_found) ?
		(NUM_DETECTORS'(1) << pick) : '0;
	// A slot freed this cycle can catch a new edge
	assign accept = edges & (~pending | take);

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_a <= '0;
			sync_b <= '0;
			sync_prev <= '0;
			timestamp <= '0;
			pending <= '0;
			marker_pending <= 1'b0;
			rec_valid <= 1'b0;
		end else begin
			sync_a <= detectors;
			sync_b <= sync_a;
			sync_prev <= sync_b;
			if (tag_event)
				timestamp <= '0;
			else if (tag_run)
				timestamp <= timestamp + 1'b1;
			pending <= (pending & ~take) | accept;
			if (tag_event)
				marker_pending <= 1'b1;
			else if (offer)
				marker_pending <= 1'b0;
			if (offer)
				rec_valid <= marker_pending || pick_found;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_DETECTORS; i++) begin
			if (accept[i])
				pending_time[i] <= timestamp;
		end
		if (tag_event) begin
			marker_run <= tag_run;
			marker_mask <= tag_mask;
		end
		if (offer) begin
			if (marker_pending) begin
				rec_q.marker.kind <= MARKER_KIND;
				rec_q.marker.reserved <= '0;
				rec_q.marker.running <= marker_run;
				rec_q.marker.mask <= marker_mask;
			end else begin
				rec_q.tag.channel <= 4'(pick);
				rec_q.tag.timestamp <= pending_time[pick];
			end
		end
	end

	assign rec_data = rec_q;

endmodule

`default_nettype wire

// File: source/pulse_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_sequencer import timetag_pkg::*; (
	input wire clk,
	input wire reset,
	input wire seq_run,
	input wire [COUNT_WIDTH-1:0] seq_high,
	input wire [COUNT_WIDTH-1:0] seq_low,
	input wire [NUM_LASERS-1:0] seq_mask,
	output logic [NUM_LASERS-1:0] laser_en
);

	logic active;
	logic phase;
	logic [COUNT_WIDTH-1:0] count;
	logic [COUNT_WIDTH-1:0] high_load;
	logic [COUNT_WIDTH-1:0] low_load;

	// Counter runs down to zero, so load length minus one; zero acts as one
	assign high_load = (seq_high == '0) ? '0 : seq_high - 1'b1;
	assign low_load = (seq_low == '0) ? '0 : seq_low - 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			phase <= 1'b0;
			count <= '0;
		end else begin
			active <= seq_run;
			if (!seq_run) begin
				phase <= 1'b0;
				count <= '0;
			end else if (!active) begin
				// Start always opens with the high phase
				phase <= 1'b1;
				count <= high_load;
			end else if (count == '0) begin
				phase <= !phase;
				count <= phase ? low_load : high_load;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	assign laser_en = {NUM_LASERS{phase}} & seq_mask;

endmodule

`default_nettype wire

// File: source/control_regs.sv
`timescale 1ns/1ps
`default_nettype none

module control_regs import timetag_pkg::*; (
	input wire clk,
	input wire reset,
	input wire reg_wr,
	input wire [7:0] reg_addr,
	input wire [31:0] reg_data,
	output logic [NUM_DETECTORS-1:0] tag_mask,
	output logic tag_run,
	output logic tag_event,
	output logic seq_run,
	output logic [COUNT_WIDTH-1:0] seq_high,
	output logic [COUNT_WIDTH-1:0] seq_low,
	output logic [NUM_LASERS-1:0] seq_mask
);

	always_ff @(posedge clk) begin
		if (reset) begin
			tag_mask <= '0;
			tag_event <= 1'b0;
			seq_run <= 1'b0;
			seq_high <= '0;
			seq_low <= '0;
			seq_mask <= '0;
		end else begin
			tag_event <= 1'b0;
			if (reg_wr) begin
				case (reg_addr)
					REG_TAG_CTRL: begin
						tag_mask <= reg_data[NUM_DETECTORS-1:0];
						tag_event <= 1'b1;
					end
					REG_SEQ_CTRL: seq_run <= reg_data[0];
					REG_SEQ_HIGH: seq_high <= reg_data[COUNT_WIDTH-1:0];
					REG_SEQ_LOW: seq_low <= reg_data[COUNT_WIDTH-1:0];
					REG_SEQ_MASK: seq_mask <= reg_data[NUM_LASERS-1:0];
					default: ;
				endcase
			end
		end
	end

	// Any enabled detector means tagging is running
	assign tag_run = |tag_mask;

endmodule

`default_nettype wire

// File: source/cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_parser import timetag_pkg::*; (
	input wire clk,
	input wire reset,
	input wire [7:0] cmd_data,
	input wire cmd_valid,
	output logic cmd_ready,
	output logic reg_wr,
	output logic [7:0] reg_addr,
	output logic [31:0] reg_data
);

	logic [1:0] state;
	logic [2:0] remaining;
	logic [1:0] byte_idx;
	logic take;

	assign take = cmd_valid && cmd_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_ready <= 1'b0;
			reg_wr <= 1'b0;
			state <= PARSE_HUNT;
			remaining <= 3'd0;
			byte_idx <= 2'd0;
		end else begin
			// Never stalls, so ready just follows reset release
			cmd_ready <= 1'b1;
			reg_wr <= 1'b0;
			if (take) begin
				case (state)
					PARSE_HUNT: begin
						if (cmd_data == CMD_HEADER)
							state <= PARSE_LENGTH;
					end
					PARSE_LENGTH: begin
						if (cmd_data != 8'd0 && cmd_data <= CMD_MAX_LEN) begin
							remaining <= cmd_data[2:0];
							state <= PARSE_ADDRESS;
						end else begin
							state <= PARSE_HUNT;
						end
					end
					PARSE_ADDRESS: begin
						byte_idx <= 2'd0;
						state <= PARSE_PAYLOAD;
					end
					default: begin
						byte_idx <= byte_idx + 2'd1;
						remaining <= remaining - 3'd1;
						if (remaining == 3'd1) begin
							reg_wr <= 1'b1;
							state <= PARSE_HUNT;
						end
					end
				endcase
			end
		end
	end

	// Address and payload bytes, least significant byte first
	always_ff @(posedge clk) begin
		if (take && state == PARSE_ADDRESS) begin
			reg_addr <= cmd_data;
			reg_data <= '0;
		end else if (take && state == PARSE_PAYLOAD) begin
			reg_data[byte_idx*8 +: 8] <= cmd_data;
		end
	end

endmodule

`default_nettype wire

// File: source/timetag_pkg.sv
`default_nettype none

package timetag_pkg;

	// Host command framing
	localparam logic [7:0] CMD_HEADER = 8'hAA;
	localparam int CMD_MAX_LEN = 4;

	localparam logic [7:0] REG_TAG_CTRL = 8'h01;
	localparam logic [7:0] REG_SEQ_CTRL = 8'h02;
	localparam logic [7:0] REG_SEQ_HIGH = 8'h04;
	localparam logic [7:0] REG_SEQ_LOW = 8'h05;
	localparam logic [7:0] REG_SEQ_MASK = 8'h06;

	// Parser FSM encoding
	localparam logic [1:0] PARSE_HUNT = 2'd0;
	localparam logic [1:0] PARSE_LENGTH = 2'd1;
	localparam logic [1:0] PARSE_ADDRESS = 2'd2;
	localparam logic [1:0] PARSE_PAYLOAD = 2'd3;

	localparam int NUM_DETECTORS = 4;
	localparam int NUM_LASERS = 4;
	localparam int TIME_WIDTH = 28;
	localparam int COUNT_WIDTH = 16;

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);

	localparam logic [3:0] MARKER_KIND = 4'hF;

	// One 32-bit record word, either a detector tag or a run marker
	typedef union packed {
		struct packed {
			logic [3:0] channel;
			logic [TIME_WIDTH-1:0] timestamp;
		} tag;
		struct packed {
			logic [3:0] kind;
			logic [22:0] reserved;
			logic running;
			logic [3:0] mask;
		} marker;
	} event_record_t;

endpackage

`default_nettype wire
